// File: logic/t04_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, MMIO address map and state enums
// for the keypad, display and Wishbone MMIO tile
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package t04_pkg;

    // Bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    // Column * 4 + row
    typedef logic [3:0]  key_code_t;
    typedef logic [7:0]  lcd_byte_t;

    // Address map
    localparam addr_t KEYPAD_ADDR  = 32'h0000_E000;
    localparam addr_t DISPLAY_BASE = 32'h0000_D000;
    // 256-byte display window
    localparam addr_t DISPLAY_MASK = 32'hFFFF_FF00;

    // Event-valid flag in the keypad status word
    localparam int unsigned KEY_VALID_BIT = 8;

    typedef enum logic {WB_IDLE, WB_BUSY} wb_state_t;

    typedef enum logic [1:0] {LCD_IDLE, LCD_SETUP, LCD_STROBE, LCD_HOLD} lcd_state_t;

endpackage

// File: logic/t04_ifs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal request paths from the MMIO decoder:
// Wishbone request interface, display write interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

// MMIO to Wishbone master, req held until done pulses
interface wb_req_if import t04_pkg::*; ();
    addr_t adr;
    data_t wdata;
    logic  we;
    logic  req;
    data_t rdata;
    logic  done;

    modport mmio   (output adr, wdata, we, req, input rdata, done);
    modport master (input adr, wdata, we, req, output rdata, done);
endinterface

// MMIO to screen writer, wen held until ack pulses
interface disp_if import t04_pkg::*; ();
    logic  wen;
    addr_t addr;
    data_t data;
    logic  ack;

    modport mmio   (output wen, addr, data, input ack);
    modport writer (input wen, addr, data, output ack);
endinterface

// File: logic/t04_keypad.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 4x4 keypad scanner: column timer, row sampling,
// press edge detect and the key event register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module t04_keypad
    import t04_pkg::*;
#(
    parameter int unsigned SCAN_DIV = 1000
) (
    input  logic      clk,
    input  logic      rst,
    input  logic [3:0] row,
    input  logic      key_clear,
    output logic [3:0] column,
    output logic      key_event,
    output key_code_t key_code,
    output data_t     key_status
);
    localparam int unsigned CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic [1:0]       col_idx;
    logic [3:0]       row_meta;
    logic [3:0]       row_sync;
    // One bit per key, row pattern seen on the last scan
    logic [15:0]      prev_keys;
    logic [1:0]       row_idx;
    logic             row_hit;
    logic             win_end;
    logic             press;
    logic             key_valid;
    key_code_t        new_code;

    // Last cycle of the current column window
    assign win_end = (|column) && (div_cnt == CNT_W'(SCAN_DIV - 1));

    // Lowest set row wins
    always_comb begin
        row_idx = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (row_sync[r]) begin
                row_idx = 2'(r);
            end
        end
    end

    assign row_hit  = |row_sync;
    assign new_code = {col_idx, row_idx};
    // Rising edge of that key only
    assign press    = win_end && row_hit && !prev_keys[new_code];

    // Column scan, idle low until the first cycle out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            column  <= 4'b0000;
            col_idx <= 2'd0;
            div_cnt <= '0;
        end else if (column == 4'b0000) begin
            column  <= 4'b0001;
            col_idx <= 2'd0;
            div_cnt <= '0;
        end else if (win_end) begin
            column  <= {column[2:0], column[3]};
            col_idx <= col_idx + 2'd1;
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Rows come straight from the pads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_meta <= 4'b0000;
            row_sync <= 4'b0000;
        end else begin
            row_meta <= row;
            row_sync <= row_meta;
        end
    end

    // Event register, a new press beats a clear
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_keys <= '0;
            key_valid <= 1'b0;
            key_code  <= '0;
            key_event <= 1'b0;
        end else begin
            key_event <= press;
            if (win_end) begin
                prev_keys[{col_idx, 2'b00} +: 4] <= row_sync;
            end
            if (press) begin
                key_valid <= 1'b1;
                key_code  <= new_code;
            end else if (key_clear) begin
                key_valid <= 1'b0;
                key_code  <= '0;
            end
        end
    end

    // Status word: valid flag plus code in the low nibble
    always_comb begin
        key_status                = '0;
        key_status[KEY_VALID_BIT] = key_valid;
        key_status[3:0]           = key_code;
    end

endmodule

// File: logic/t04_mmio.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMIO decoder: latches a core access, routes it to
// keypad, display or Wishbone, and returns core_ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module t04_mmio
    import t04_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   en,
    input  addr_t  core_addr,
    input  data_t  core_wdata,
    input  logic   core_read,
    input  logic   core_write,
    input  data_t  key_status,
    output data_t  core_rdata,
    output logic   core_ack,
    output logic   key_clear,
    wb_req_if.mmio wb,
    disp_if.mmio   disp
);
    typedef enum logic [2:0] {ST_IDLE, ST_KEY, ST_WB, ST_DISP, ST_ACK} mmio_state_t;

    mmio_state_t state;
    addr_t       acc_addr;
    data_t       acc_wdata;
    logic        acc_we;
    logic        wb_req;
    logic        disp_wen;
    logic        start;
    logic        hit_key;
    logic        hit_disp;

    // Core still holds its request during the ack cycle
    assign start    = en && (core_read || core_write) && !core_ack && (state == ST_IDLE);
    assign hit_key  = core_read && (core_addr == KEYPAD_ADDR);
    assign hit_disp = (core_addr & DISPLAY_MASK) == DISPLAY_BASE;

    // Access fields, stable for the whole transfer
    always_ff @(posedge clk) begin
        if (start) begin
            acc_addr  <= core_addr;
            acc_wdata <= core_wdata;
            acc_we    <= core_write;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            wb_req     <= 1'b0;
            disp_wen   <= 1'b0;
            core_ack   <= 1'b0;
            core_rdata <= '0;
        end else begin
            core_ack <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        if (hit_key) begin
                            state <= ST_KEY;
                        end else if (hit_disp && core_write) begin
                            state    <= ST_DISP;
                            disp_wen <= 1'b1;
                        end else if (hit_disp) begin
                            // Display is write only
                            state      <= ST_ACK;
                            core_rdata <= '0;
                        end else begin
                            state  <= ST_WB;
                            wb_req <= 1'b1;
                        end
                    end
                end
                // Status sampled here, cleared in the same edge
                ST_KEY: begin
                    core_rdata <= key_status;
                    state      <= ST_ACK;
                end
                ST_ACK: begin
                    core_ack <= 1'b1;
                    state    <= ST_IDLE;
                end
                ST_WB: begin
                    if (wb.done) begin
                        wb_req     <= 1'b0;
                        core_rdata <= acc_we ? '0 : wb.rdata;
                        core_ack   <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                ST_DISP: begin
                    if (disp.ack) begin
                        disp_wen   <= 1'b0;
                        core_rdata <= '0;
                        core_ack   <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Read clears the event
    assign key_clear = (state == ST_KEY);

    assign wb.adr    = acc_addr;
    assign wb.wdata  = acc_wdata;
    assign wb.we     = acc_we;
    assign wb.req    = wb_req;
    assign disp.wen  = disp_wen;
    assign disp.addr = acc_addr;
    assign disp.data = acc_wdata;

endmodule

// File: logic/t04_wb_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Classic Wishbone single-transfer master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module t04_wb_master
    import t04_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  data_t    dat_i,
    input  logic     ack_i,
    output addr_t    adr_o,
    output data_t    dat_o,
    output logic [3:0] sel_o,
    output logic     we_o,
    output logic     stb_o,
    output logic     cyc_o,
    wb_req_if.master req
);
    wb_state_t state;
    logic      done_q;
    data_t     rdata_q;
    logic      busy;

    assign busy = (state == WB_BUSY);

    // done still high blocks a restart on the old req
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= WB_IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                WB_IDLE: if (req.req && !done_q) state <= WB_BUSY;
                WB_BUSY: begin
                    if (ack_i) begin
                        state  <= WB_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // Read data taken on the ack edge
    always_ff @(posedge clk) begin
        if (busy && ack_i) begin
            rdata_q <= dat_i;
        end
    end

    assign cyc_o     = busy;
    assign stb_o     = busy;
    assign we_o      = busy && req.we;
    // Word access only
    assign sel_o     = busy ? 4'hF : 4'h0;
    assign adr_o     = req.adr;
    assign dat_o     = req.wdata;
    assign req.done  = done_q;
    assign req.rdata = rdata_q;

endmodule

// File: logic/t04_screen_writer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8080-style LCD write cycle generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module t04_screen_writer
    import t04_pkg::*;
#(
    parameter int unsigned WR_LOW_CYCLES = 2
) (
    input  logic      clk,
    input  logic      rst,
    output logic      csx,
    output logic      dcx,
    output logic      wrx,
    output lcd_byte_t screen_data,
    disp_if.writer    disp
);
    localparam int unsigned CNT_W = (WR_LOW_CYCLES > 1) ? $clog2(WR_LOW_CYCLES) : 1;

    lcd_state_t       state;
    logic [CNT_W-1:0] low_cnt;
    logic             ack_q;
    logic             launch;

    // ack still high means wen is the finished request
    assign launch = (state == LCD_IDLE) && disp.wen && !ack_q;

    // SETUP, then wrx low, then one HOLD cycle before ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= LCD_IDLE;
            low_cnt <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                LCD_IDLE: if (launch) state <= LCD_SETUP;
                LCD_SETUP: begin
                    low_cnt <= '0;
                    state   <= LCD_STROBE;
                end
                LCD_STROBE: begin
                    if (low_cnt == CNT_W'(WR_LOW_CYCLES - 1)) begin
                        state <= LCD_HOLD;
                    end else begin
                        low_cnt <= low_cnt + 1'b1;
                    end
                end
                LCD_HOLD: begin
                    state <= LCD_IDLE;
                    ack_q <= 1'b1;
                end
                default: state <= LCD_IDLE;
            endcase
        end
    end

    // Address bit 2 picks command (0) or data (1)
    always_ff @(posedge clk) begin
        if (launch) begin
            dcx         <= disp.addr[2];
            screen_data <= disp.data[7:0];
        end
    end

    assign csx      = (state == LCD_IDLE);
    assign wrx      = (state != LCD_STROBE);
    assign disp.ack = ack_q;

endmodule

// File: logic/t04_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMIO tile top: keypad, decoder, Wishbone master
// and screen writer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module t04_top
    import t04_pkg::*;
#(
    parameter int unsigned SCAN_DIV      = 1000,
    parameter int unsigned WR_LOW_CYCLES = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       en,
    // Core data port
    input  addr_t      core_addr,
    input  data_t      core_wdata,
    input  logic       core_read,
    input  logic       core_write,
    output data_t      core_rdata,
    output logic       core_ack,
    // Keypad
    input  logic [3:0] row,
    output logic [3:0] column,
    // Wishbone
    output addr_t      adr_o,
    output data_t      dat_o,
    output logic [3:0] sel_o,
    output logic       we_o,
    output logic       stb_o,
    output logic       cyc_o,
    input  data_t      dat_i,
    input  logic       ack_i,
    // LCD write bus
    output logic       csx,
    output logic       dcx,
    output logic       wrx,
    output lcd_byte_t  screen_data
);
    data_t key_status;
    logic  key_clear;

    wb_req_if wb_bus ();
    disp_if   disp_bus ();

    // Event strobe and code not used by the decoder
    t04_keypad #(.SCAN_DIV(SCAN_DIV)) keypad (
        .clk(clk), .rst(rst), .row(row), .key_clear(key_clear),
        .column(column), .key_event(), .key_code(), .key_status(key_status)
    );

    t04_mmio mmio (
        .clk(clk), .rst(rst), .en(en),
        .core_addr(core_addr), .core_wdata(core_wdata),
        .core_read(core_read), .core_write(core_write),
        .key_status(key_status), .core_rdata(core_rdata),
        .core_ack(core_ack), .key_clear(key_clear),
        .wb(wb_bus), .disp(disp_bus)
    );

    t04_wb_master wb_master (
        .clk(clk), .rst(rst), .dat_i(dat_i), .ack_i(ack_i),
        .adr_o(adr_o), .dat_o(dat_o), .sel_o(sel_o), .we_o(we_o),
        .stb_o(stb_o), .cyc_o(cyc_o), .req(wb_bus)
    );

    t04_screen_writer #(.WR_LOW_CYCLES(WR_LOW_CYCLES)) screen (
        .clk(clk), .rst(rst), .csx(csx), .dcx(dcx), .wrx(wrx),
        .screen_data(screen_data), .disp(disp_bus)
    );

endmodule

// File: verif/t04_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and power-on reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module t04_clk_gen #(
    parameter int unsigned HALF_PERIOD = 5,
    parameter int unsigned RST_CYCLES  = 3
) (
    output logic clk,
    output logic rst
);
    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset drops on the falling edge after the last held cycle
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: verif/t04_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone and LCD bus protocol assertions,
// bound into the Wishbone master and screen writer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module t04_sva (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic csx,
    input logic wrx
);
    // Failures seen so far, polled by the testbench
    int err_cnt = 0;

    // Strobe only inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb |-> cyc)
        else begin
            err_cnt++;
            $error("stb high without cyc");
        end

    // Strobe stays up until the slave answers
    stb_until_ack: assert property (@(posedge clk) disable iff (rst) (stb && !ack) |=> stb)
        else begin
            err_cnt++;
            $error("stb dropped before ack");
        end

    // Write strobe only inside chip select
    wrx_in_csx: assert property (@(posedge clk) disable iff (rst) !wrx |-> !csx)
        else begin
            err_cnt++;
            $error("wrx low while csx high");
        end

endmodule

// Wishbone side, LCD inputs tied idle
bind t04_wb_master t04_sva wb_sva (
    .clk(clk), .rst(rst), .cyc(cyc_o), .stb(stb_o), .ack(ack_i),
    .csx(1'b1), .wrx(1'b1)
);

// LCD side, Wishbone inputs tied idle
bind t04_screen_writer t04_sva lcd_sva (
    .clk(clk), .rst(rst), .cyc(1'b0), .stb(1'b0), .ack(1'b0),
    .csx(csx), .wrx(wrx)
);

// File: verif/t04_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMIO tile testbench: core model driven from the
// pattern file, keypad matrix model, Wishbone slave
// with random wait states, result checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module t04_tb
    import t04_pkg::*;
;
    localparam int unsigned SCAN_DIV   = 8;
    localparam int          MAX_PAT    = 64;
    localparam int          ACK_LIMIT  = 100;
    localparam int          EN_LOW_CYC = 20;
    // Several full keypad scans
    localparam int          KEY_LIMIT  = 8 * SCAN_DIV;

    logic       clk;
    logic       rst;
    logic       en;
    addr_t      core_addr;
    data_t      core_wdata;
    logic       core_read;
    logic       core_write;
    data_t      core_rdata;
    logic       core_ack;
    logic [3:0] row = 4'h0;
    logic [3:0] column;
    addr_t      adr_o;
    data_t      dat_o;
    logic [3:0] sel_o;
    logic       we_o;
    logic       stb_o;
    logic       cyc_o;
    data_t      dat_i = '0;
    logic       ack_i = 1'b0;
    logic       csx;
    logic       dcx;
    logic       wrx;
    lcd_byte_t  screen_data;

    // Four words per line: op, address or key, data, expected
    logic [31:0] pat_mem [0:MAX_PAT*4-1];

    // Keys held on the matrix
    logic [1:0] held_col = 2'd0;
    logic [3:0] held_rows = 4'h0;

    // Slave memory and what the last transfer looked like
    data_t      slave_mem [0:15];
    integer     seed = 85409;
    int         wait_left = -1;
    int         xfer_cnt = 0;
    addr_t      seen_adr;
    logic [3:0] seen_sel;
    logic       seen_we;

    // LCD bus at the last wrx rising edge
    logic       rise_csx;
    logic       rise_dcx;
    lcd_byte_t  rise_byte;

    t04_clk_gen clk_gen (.clk(clk), .rst(rst));

    t04_top #(.SCAN_DIV(SCAN_DIV)) DUT (
        .clk(clk), .rst(rst), .en(en),
        .core_addr(core_addr), .core_wdata(core_wdata),
        .core_read(core_read), .core_write(core_write),
        .core_rdata(core_rdata), .core_ack(core_ack),
        .row(row), .column(column),
        .adr_o(adr_o), .dat_o(dat_o), .sel_o(sel_o), .we_o(we_o),
        .stb_o(stb_o), .cyc_o(cyc_o), .dat_i(dat_i), .ack_i(ack_i),
        .csx(csx), .dcx(dcx), .wrx(wrx), .screen_data(screen_data)
    );

    task automatic fail_run();
        $display("** FAIL **");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_code(input string name, input key_code_t got, input key_code_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_byte(input string name, input lcd_byte_t got, input lcd_byte_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_mask(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %s: got %0h expected %0h", name, got, exp);
            fail_run();
        end
    endtask

    // 256-byte display window from its base
    function automatic logic in_display(input addr_t a);
        return (a >= DISPLAY_BASE) && (a < DISPLAY_BASE + 32'd256);
    endfunction

    // Key number of the held column and its lowest held row
    function automatic key_code_t held_key_code(input logic [1:0] col, input logic [3:0] rows);
        int r;
        r = 0;
        while (r < 3 && !rows[r]) begin
            r++;
        end
        return key_code_t'(col * 4 + r);
    endfunction

    // Matrix: held rows answer while their column is driven
    always @(negedge clk) begin
        row <= column[held_col] ? held_rows : 4'h0;
    end

    // Wishbone slave, 0 to 3 wait states per transfer
    always @(negedge clk) begin
        if (cyc_o && stb_o && !ack_i) begin
            if (wait_left < 0) begin
                wait_left = $random(seed) & 3;
            end
            if (wait_left == 0) begin
                seen_adr = adr_o;
                seen_sel = sel_o;
                seen_we  = we_o;
                if (we_o) begin
                    slave_mem[adr_o[5:2]] = dat_o;
                end
                dat_i     <= slave_mem[adr_o[5:2]];
                ack_i     <= 1'b1;
                xfer_cnt  = xfer_cnt + 1;
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end else begin
            ack_i <= 1'b0;
        end
    end

    // Bound assertion failures end the run too
    always @(negedge clk) begin
        if (DUT.wb_master.wb_sva.err_cnt != 0 || DUT.screen.lcd_sva.err_cnt != 0) begin
            $display("A bus protocol assertion failed");
            fail_run();
        end
    end

    // Waits until one column line reaches the given level
    task automatic wait_column(input logic [1:0] col, input logic level);
        int n;
        n = 0;
        while (column[col] !== level) begin
            @(negedge clk);
            n++;
            if (n > KEY_LIMIT) begin
                $display("Keypad column %0d never went to %0b", col, level);
                fail_run();
            end
        end
    endtask

    // New key state, then one whole scan window of that column
    task automatic hold_keys(input logic [1:0] col, input logic [3:0] rows);
        @(negedge clk);
        held_col  = col;
        held_rows = rows;
        wait_column(col, 1'b0);
        wait_column(col, 1'b1);
        wait_column(col, 1'b0);
    endtask

    // One core access; lat counts falling edges up to core_ack
    task automatic run_access(input logic is_write, input addr_t addr, input data_t wdata,
                              input logic en_low_first, output data_t rdata,
                              output int lat, output int wr_edges);
        int   n;
        logic prev_wrx;
        @(negedge clk);
        en         = !en_low_first;
        core_addr  = addr;
        core_wdata = wdata;
        core_read  = !is_write;
        core_write = is_write;
        if (en_low_first) begin
            for (n = 0; n < EN_LOW_CYC; n++) begin
                @(negedge clk);
                if (core_ack || cyc_o) begin
                    $display("An access started while en was low");
                    fail_run();
                end
            end
            en = 1'b1;
        end
        prev_wrx = wrx;
        wr_edges = 0;
        lat      = 0;
        do begin
            @(negedge clk);
            lat++;
            if (!prev_wrx && wrx) begin
                wr_edges++;
                rise_csx  = csx;
                rise_dcx  = dcx;
                rise_byte = screen_data;
            end
            prev_wrx = wrx;
            if (lat > ACK_LIMIT && !core_ack) begin
                $display("No core_ack within %0d cycles for address %h", ACK_LIMIT, addr);
                fail_run();
            end
        end while (!core_ack);
        rdata = core_rdata;
        // Request goes away in the cycle after the ack
        core_read  = 1'b0;
        core_write = 1'b0;
    endtask

    initial begin
        int          idx;
        int          n;
        int          lat;
        int          edges;
        int          xfer_before;
        logic [31:0] op;
        addr_t       addr;
        data_t       wdata;
        data_t       exp_val;
        data_t       rdata;
        logic        is_wr;
        logic        to_wb;
        en         = 1'b1;
        core_addr  = '0;
        core_wdata = '0;
        core_read  = 1'b0;
        core_write = 1'b0;
        $readmemh("verif/t04_patterns.txt", pat_mem);

        // Idle bus levels while reset is held
        @(negedge clk);
        check_bit("cyc_o", cyc_o, 1'b0);
        check_bit("stb_o", stb_o, 1'b0);
        check_bit("we_o", we_o, 1'b0);
        check_bit("core_ack", core_ack, 1'b0);
        check_bit("csx", csx, 1'b1);
        check_bit("wrx", wrx, 1'b1);
        check_mask("column", column, 4'h0);
        n = 0;
        while (rst) begin
            @(negedge clk);
            n++;
            if (n > 20) begin
                $display("Reset was never released");
                fail_run();
            end
        end

        idx = 0;
        while (idx < MAX_PAT && pat_mem[idx*4] != 32'h0) begin
            op      = pat_mem[idx*4];
            addr    = pat_mem[idx*4+1];
            wdata   = pat_mem[idx*4+2];
            exp_val = pat_mem[idx*4+3];
            case (op)
                1, 2, 3, 5: begin
                    is_wr       = (op == 1) || (op == 3);
                    to_wb       = !in_display(addr) && !(addr == KEYPAD_ADDR && !is_wr);
                    xfer_before = xfer_cnt;
                    run_access(is_wr, addr, wdata, op == 5, rdata, lat, edges);
                    if (!is_wr) begin
                        check_data("core_rdata", rdata, exp_val);
                    end
                    // Keypad answers two edges after the request
                    if (addr == KEYPAD_ADDR && !is_wr) begin
                        if (exp_val[KEY_VALID_BIT]) begin
                            check_code("key code", rdata[3:0],
                                       held_key_code(held_col, held_rows));
                        end
                        check_count("keypad core_ack latency", lat - 1, 2);
                    end
                    if (in_display(addr) && is_wr) begin
                        check_count("wrx rising edges", edges, 1);
                        check_bit("csx at wrx rise", rise_csx, 1'b0);
                        check_bit("dcx", rise_dcx, exp_val[8]);
                        check_byte("screen_data", rise_byte, exp_val[7:0]);
                    end else begin
                        check_count("wrx rising edges", edges, 0);
                    end
                    if (to_wb) begin
                        check_count("Wishbone transfers", xfer_cnt - xfer_before, 1);
                        check_data("adr_o", seen_adr, addr);
                        check_mask("sel_o", seen_sel, 4'hF);
                        check_bit("we_o", seen_we, is_wr);
                    end else begin
                        check_count("Wishbone transfers", xfer_cnt - xfer_before, 0);
                    end
                end
                4: hold_keys(addr[3:2], wdata[3:0]);
                default: begin
                    $display("Unknown operation %0h on pattern line %0d", op, idx);
                    fail_run();
                end
            endcase
            idx++;
        end

        if (idx == 0) begin
            $display("No patterns were read");
            fail_run();
        end else begin
            $display("%0d patterns checked", idx);
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: verif/t04_patterns.txt
// op addr_or_key data expected, all hex
// op 1 write, 2 read, 3 display write (exp bit 8 dcx, low byte data), 4 hold rows, 5 read with en low first, 0 end
1 00001000 12345678 00000000
1 00001004 deadbeef 00000000
1 00002010 a5a55a5a 00000000
2 00001000 00000000 12345678
2 00001004 00000000 deadbeef
2 00002010 00000000 a5a55a5a
3 0000d000 0000002c 0000002c
3 0000d004 000012a7 000001a7
3 0000d0fc 00000055 00000155
3 0000d0f8 ffffff01 00000001
// key 6 is column 1 row 2
4 00000006 00000004 00000000
2 0000e000 00000000 00000106
2 0000e000 00000000 00000000
4 00000006 00000000 00000000
4 00000006 00000004 00000000
2 0000e000 00000000 00000106
4 00000006 00000000 00000000
// column 2 rows 1 and 3, lower row wins
4 00000009 0000000a 00000000
2 0000e000 00000000 00000109
4 00000009 00000000 00000000
5 00001004 00000000 deadbeef
2 0000d010 00000000 00000000
0 00000000 00000000 00000000

// File: t04_top.f
logic/t04_pkg.sv
logic/t04_ifs.sv
logic/t04_keypad.sv
logic/t04_mmio.sv
logic/t04_wb_master.sv
logic/t04_screen_writer.sv
logic/t04_top.sv
verif/t04_clk_gen.sv
verif/t04_sva.sv
verif/t04_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the MMIO tile testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module t04_tb -f t04_top.f
# Assertion errors keep running so the testbench can report them
./obj_dir/Vt04_tb +verilator+error+limit+100
